// File: compile.f
+incdir+.
exu_pkg.sv
exu_decoder.sv
exu_regfile.sv
exu_execute.sv
exu_top.sv
tb_clock_gen.sv
exu_asserts.sv
exu_tb.sv

// File: exu_asserts.sv
`default_nettype none

module exu_asserts
	import exu_pkg::*;
(
	input logic    clk,
	input logic    reset,
	input logic    inst_valid,
	input decoded_t dec,
	input wb_t     wb,
	input retire_t retire
);

	timeunit 1ns;
	timeprecision 1ps;

	// The record is cleared at every edge that sees reset.
	a_idle_in_reset: assert property (@(posedge clk) reset |=> !retire.valid)
		else $error("retire.valid high after a reset edge");

	a_retire_follows_strobe: assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> (retire.valid == $past(inst_valid)))
		else $error("retire.valid does not follow inst_valid by one cycle");

	a_no_illegal_write: assert property (@(posedge clk) disable iff (reset)
		!(wb.we && dec.illegal))
		else $error("register write enabled for an illegal instruction");

endmodule

`default_nettype wire

// File: exu_decoder.sv
`default_nettype none

`include "exu_settings.svh"

module exu_decoder
	import exu_pkg::*;
(
	input  logic [31:0] inst,
	output decoded_t    dec
);

	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;

	localparam logic [2:0] F3_ADDI  = 3'b000;
	localparam logic [2:0] F3_SLLI  = 3'b001;
	localparam logic [2:0] F3_SLTI  = 3'b010;
	localparam logic [2:0] F3_SLTIU = 3'b011;
	localparam logic [2:0] F3_XORI  = 3'b100;
	localparam logic [2:0] F3_SRXI  = 3'b101; // srli and srai share it.
	localparam logic [2:0] F3_ORI   = 3'b110;
	localparam logic [2:0] F3_ANDI  = 3'b111;

	localparam logic [6:0] F7_ZERO = 7'b0000000;
	localparam logic [6:0] F7_SRA  = 7'b0100000;

	logic [6:0]                 opcode;
	logic [2:0]                 funct3;
	logic [6:0]                 funct7;
	logic [`EXU_REG_ADDR_W-1:0] rd_idx;
	logic [`EXU_REG_ADDR_W-1:0] rs1_idx;
	logic [`EXU_XLEN-1:0]       imm_i;
	logic [`EXU_XLEN-1:0]       imm_sh;
	logic [`EXU_XLEN-1:0]       imm_u;

	assign opcode  = inst[6:0];
	assign funct3  = inst[14:12];
	assign funct7  = inst[31:25];
	assign rd_idx  = inst[11:7];
	assign rs1_idx = inst[19:15];

	assign imm_i  = {{(`EXU_XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_sh = {{(`EXU_XLEN-5){1'b0}}, inst[24:20]}; // Shift amount only.
	assign imm_u  = {inst[31:12], 12'b0};

	always_comb begin
		dec.op      = ALU_ADD;
		dec.rd      = rd_idx;
		dec.rs1     = rs1_idx;
		dec.imm     = imm_i;
		dec.illegal = 1'b0;

		case (opcode)
			OPC_OP_IMM: begin
				case (funct3)
					F3_ADDI: begin
						dec.op = ALU_ADD;
					end
					F3_SLTI: begin
						dec.op = ALU_SLT;
					end
					F3_SLTIU: begin
						dec.op = ALU_SLTU; // Immediate still sign-extended.
					end
					F3_XORI: begin
						dec.op = ALU_XOR;
					end
					F3_ORI: begin
						dec.op = ALU_OR;
					end
					F3_ANDI: begin
						dec.op = ALU_AND;
					end
					F3_SLLI: begin
						dec.op      = ALU_SLL;
						dec.imm     = imm_sh;
						dec.illegal = (funct7 != F7_ZERO);
					end
					F3_SRXI: begin
						dec.imm = imm_sh;
						if (funct7 == F7_ZERO) begin
							dec.op = ALU_SRL;
						end else if (funct7 == F7_SRA) begin
							dec.op = ALU_SRA;
						end else begin
							dec.illegal = 1'b1;
						end
					end
					default: begin
						dec.illegal = 1'b1;
					end
				endcase
			end
			OPC_LUI: begin
				dec.op  = ALU_LUI;
				dec.rs1 = '0; // Nothing to read.
				dec.imm = imm_u;
			end
			default: begin
				dec.illegal = 1'b1; // Everything outside the kept group.
			end
		endcase
	end

endmodule

`default_nettype wire

// File: exu_execute.sv
`default_nettype none

`include "exu_settings.svh"

module exu_execute
	import exu_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 inst_valid,
	input  decoded_t             dec,
	input  logic [`EXU_XLEN-1:0] rs1_val,
	output wb_t                  wb,
	output retire_t              retire
);

	logic [`EXU_XLEN-1:0] result;
	logic [4:0]           shamt;
	logic                 lt_signed;
	logic                 lt_unsigned;
	retire_t              retire_next;

	assign shamt       = dec.imm[4:0]; // Low five immediate bits.
	assign lt_signed   = $signed(rs1_val) < $signed(dec.imm);
	assign lt_unsigned = rs1_val < dec.imm;

	always_comb begin
		case (dec.op)
			ALU_ADD: begin
				result = rs1_val + dec.imm;
			end
			ALU_SLT: begin
				result = {{(`EXU_XLEN-1){1'b0}}, lt_signed};
			end
			ALU_SLTU: begin
				result = {{(`EXU_XLEN-1){1'b0}}, lt_unsigned};
			end
			ALU_XOR: begin
				result = rs1_val ^ dec.imm;
			end
			ALU_OR: begin
				result = rs1_val | dec.imm;
			end
			ALU_AND: begin
				result = rs1_val & dec.imm;
			end
			ALU_SLL: begin
				result = rs1_val << shamt;
			end
			ALU_SRL: begin
				result = rs1_val >> shamt;
			end
			ALU_SRA: begin
				result = $unsigned($signed(rs1_val) >>> shamt); // Sign fill.
			end
			ALU_LUI: begin
				result = dec.imm;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// Taken at the edge that closes this cycle.
	always_comb begin
		wb.we    = inst_valid && !dec.illegal;
		wb.rd    = dec.rd;
		wb.value = result;
	end

	always_comb begin
		retire_next.valid   = inst_valid;
		retire_next.illegal = inst_valid && dec.illegal;
		retire_next.rd      = dec.rd;
		retire_next.value   = dec.illegal ? '0 : result;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			retire <= '0;
		end else begin
			retire <= retire_next; // One record per strobe.
		end
	end

endmodule

`default_nettype wire

// File: exu_pkg.sv
`default_nettype none

`include "exu_settings.svh"

package exu_pkg;

	// Operations kept from the register-immediate group, plus lui.
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SLT  = 4'd1,
		ALU_SLTU = 4'd2,
		ALU_XOR  = 4'd3,
		ALU_OR   = 4'd4,
		ALU_AND  = 4'd5,
		ALU_SLL  = 4'd6,
		ALU_SRL  = 4'd7,
		ALU_SRA  = 4'd8,
		ALU_LUI  = 4'd9
	} alu_op_t;

	// Output of the decoder.
	typedef struct packed {
		alu_op_t                    op;
		logic [`EXU_REG_ADDR_W-1:0] rd;
		logic [`EXU_REG_ADDR_W-1:0] rs1;
		logic [`EXU_XLEN-1:0]       imm;     // Sign-extended, shamt or U-type.
		logic                       illegal;
	} decoded_t;

	// Register file write port.
	typedef struct packed {
		logic                       we;
		logic [`EXU_REG_ADDR_W-1:0] rd;
		logic [`EXU_XLEN-1:0]       value;
	} wb_t;

	// One record per instruction, one cycle after the strobe.
	typedef struct packed {
		logic                       valid;
		logic                       illegal;
		logic [`EXU_REG_ADDR_W-1:0] rd;
		logic [`EXU_XLEN-1:0]       value;   // Zero when illegal.
	} retire_t;

endpackage

`default_nettype wire

// File: exu_regfile.sv
`default_nettype none

`include "exu_settings.svh"

module exu_regfile
	import exu_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`EXU_REG_ADDR_W-1:0] rs1,
	output logic [`EXU_XLEN-1:0]       rs1_val,
	input  wb_t                        wb
);

	logic [`EXU_XLEN-1:0] regs [1:`EXU_NUM_REGS-1]; // x0 has no storage.
	logic                 wr_en;
	logic                 rd_zero;

	assign rd_zero = (rs1 == '0);

	// Writes to x0 are dropped here.
	assign wr_en = wb.we && (wb.rd != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < `EXU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.rd] <= wb.value;
		end
	end

	// No bypass; the write has landed before the next read.
	always_comb begin
		if (rd_zero) begin
			rs1_val = '0;
		end else begin
			rs1_val = regs[rs1];
		end
	end

endmodule

`default_nettype wire

// File: exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// Widths of the RV32I execute stage.

`define EXU_XLEN 32 // Data width.

`define EXU_NUM_REGS 32 // Architectural registers, x0 included.

`define EXU_REG_ADDR_W 5 // Register index width.

`endif

// File: exu_tb.sv
`default_nettype none

`include "exu_settings.svh"

module exu_tb
	import exu_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 2000; // About 400 instructions plus reset with margin.

	logic                 clk;
	logic                 reset;
	logic [31:0]          inst;
	logic                 inst_valid;
	retire_t              retire;
	logic [`EXU_XLEN-1:0] shadow [`EXU_NUM_REGS];
	logic [31:0]          lcg_state = 32'hfd151ec4;
	retire_t              pending [$]; // Expected records in issue order.
	int                   cycle_count = 0;
	int                   check_count = 0;
	int                   error_count = 0;

	tb_clock_gen u_clock (.clk(clk));

	exu_top u_exu_top (
		.clk        (clk),
		.reset      (reset),
		.inst       (inst),
		.inst_valid (inst_valid),
		.retire     (retire)
	);

	bind exu_top exu_asserts u_exu_asserts (
		.clk        (clk),
		.reset      (reset),
		.inst_valid (inst_valid),
		.dec        (dec),
		.wb         (wb),
		.retire     (retire)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [4:0] pick_reg();
		logic [31:0] r;
		r = lcg_next();
		return 5'(r % 32'd31) + 5'd1; // Never x0.
	endfunction

	function automatic logic [31:0] op_imm_word(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
		logic [11:0] imm);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] lui_word(logic [4:0] rd, logic [19:0] upper);
		return {upper, rd, 7'b0110111};
	endfunction

	// Reference model of one instruction that also updates the shadow registers.
	task automatic predict(input logic [31:0] word, output retire_t exp);
		logic [31:0] a;
		logic [31:0] imm;
		logic [31:0] res;
		logic        ok;
		a   = shadow[word[19:15]];
		imm = {{20{word[31]}}, word[31:20]};
		res = '0;
		ok  = 1'b1;
		if (word[6:0] == 7'b0110111) begin
			res = {word[31:12], 12'h000};
		end else if (word[6:0] == 7'b0010011) begin
			case (word[14:12])
				3'd0: res = a + imm;
				3'd1: res = a << word[24:20];
				3'd2: res = {31'd0, $signed(a) < $signed(imm)};
				3'd3: res = {31'd0, a < imm};
				3'd4: res = a ^ imm;
				3'd5: begin
					if (word[30]) begin
						res = $signed(a) >>> word[24:20];
					end else begin
						res = a >> word[24:20];
					end
				end
				3'd6: res = a | imm;
				3'd7: res = a & imm;
			endcase
			if (word[14:12] == 3'd1 || word[14:12] == 3'd5) begin
				ok = (word[31:25] == 7'd0) || (word[14:12] == 3'd5 && word[31:25] == 7'h20);
			end
		end else begin
			ok = 1'b0;
		end
		exp.valid   = 1'b1;
		exp.illegal = !ok;
		exp.rd      = word[11:7];
		exp.value   = ok ? res : '0;
		if (ok && word[11:7] != 5'd0) begin
			shadow[word[11:7]] = res;
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic want);
		check_count++;
		if (got !== want) begin
			error_count++;
			$display("mismatch %s: got 0x%0h expected 0x%0h", name, got, want);
		end
	endtask

	task automatic compare_index(input string name, input logic [`EXU_REG_ADDR_W-1:0] got,
		input logic [`EXU_REG_ADDR_W-1:0] want);
		check_count++;
		if (got !== want) begin
			error_count++;
			$display("mismatch %s: got 0x%02h expected 0x%02h", name, got, want);
		end
	endtask

	task automatic compare_value(input string name, input logic [`EXU_XLEN-1:0] got,
		input logic [`EXU_XLEN-1:0] want);
		check_count++;
		if (got !== want) begin
			error_count++;
			$display("mismatch %s: got 0x%08h expected 0x%08h", name, got, want);
		end
	endtask

	task automatic check_retire(input retire_t exp);
		compare_flag("retire.valid", retire.valid, exp.valid);
		if (exp.valid) begin
			compare_flag("retire.illegal", retire.illegal, exp.illegal);
			compare_index("retire.rd", retire.rd, exp.rd);
			compare_value("retire.value", retire.value, exp.value);
		end
	endtask

	// Drives one cycle and checks the record of the cycle before.
	task automatic step(input logic [31:0] word, input logic vld);
		retire_t exp;
		exp = '0;
		@(posedge clk);
		inst       <= word;
		inst_valid <= vld;
		if (vld) begin
			predict(word, exp);
		end
		@(negedge clk);
		if (pending.size() > 0) begin
			check_retire(pending.pop_front());
		end
		pending.push_back(exp);
	endtask

	task automatic issue(input logic [31:0] word);
		step(word, 1'b1);
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		issue(lui_word(rd, value[31:12] + {19'd0, value[11]})); // Carry for negative low part.
		issue(op_imm_word(3'd0, rd, rd, value[11:0]));
	endtask

	// k is the funct3 of the operation and 8 selects srai.
	task automatic run_op(input int k, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		logic [11:0] imm12;
		imm12 = imm;
		if (k == 8) begin
			imm12 = {7'h20, imm[4:0]};
		end else if (k == 1 || k == 5) begin
			imm12 = {7'd0, imm[4:0]};
		end
		issue(op_imm_word(k == 8 ? 3'd5 : 3'(k), rd, rs1, imm12));
	endtask

	task automatic reset_and_x0();
		for (int n = 0; n < `EXU_NUM_REGS; n++) begin
			issue(op_imm_word(3'd0, 5'(n), 5'(n), 12'd0));
		end
		issue(op_imm_word(3'd0, 5'd0, 5'd0, 12'h5a3));
		issue(op_imm_word(3'd0, 5'd6, 5'd0, 12'd0)); // x0 still reads zero.
		step(32'd0, 1'b0);
	endtask

	task automatic build_constants();
		load_const(5'd3, 32'h1234_5fff);
		for (int i = 0; i < 16; i++) begin
			load_const(pick_reg(), lcg_next());
		end
		step(32'd0, 1'b0);
	endtask

	task automatic all_imm_ops();
		logic [4:0] rs;
		for (int k = 0; k < 9; k++) begin
			for (int i = 0; i < 6; i++) begin
				rs = pick_reg();
				load_const(rs, lcg_next());
				run_op(k, pick_reg(), rs, 12'(lcg_next()));
			end
		end
		load_const(5'd10, 32'h8000_1234);
		run_op(2, 5'd11, 5'd10, 12'd1);
		run_op(3, 5'd12, 5'd10, 12'd1);
		run_op(3, 5'd13, 5'd10, 12'hfff);
		run_op(5, 5'd14, 5'd10, 12'd4);
		run_op(8, 5'd15, 5'd10, 12'd4);
		step(32'd0, 1'b0);
	endtask

	task automatic dependency_chain();
		logic [4:0] src;
		src = 5'd1;
		load_const(src, lcg_next());
		for (int i = 0; i < 20; i++) begin
			run_op(i % 9, 5'(i + 2), src, 12'(lcg_next()));
			src = 5'(i + 2);
		end
		step(32'd0, 1'b0);
	endtask

	task automatic illegal_encodings();
		load_const(5'd7, 32'hcafe_0007);
		load_const(5'd8, 32'h0bad_f00d);
		load_const(5'd9, 32'h7654_3210);
		issue({7'd0, 5'd2, 5'd1, 3'd0, 5'd7, 7'b0110011}); // add x7, x1, x2
		issue({7'd0, 5'd2, 5'd1, 3'd2, 5'd8, 7'b0100011}); // sw whose low offset bits name x8
		issue(op_imm_word(3'd1, 5'd9, 5'd9, {7'h20, 5'd3}));
		for (int n = 7; n < 10; n++) begin
			issue(op_imm_word(3'd0, 5'd0, 5'(n), 12'd0));
		end
		step(32'd0, 1'b0);
	endtask

	task automatic idle_cycles();
		for (int i = 0; i < 12; i++) begin
			step(op_imm_word(3'd0, pick_reg(), 5'd0, 12'(lcg_next())), 1'b0);
		end
		for (int n = 1; n < `EXU_NUM_REGS; n++) begin
			issue(op_imm_word(3'd0, 5'd0, 5'(n), 12'd0));
		end
		step(32'd0, 1'b0);
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		inst       = op_imm_word(3'd0, 5'd5, 5'd0, 12'h7ff); // Strobe held during early reset.
		inst_valid = 1'b1;
		reset      = 1'b1;
		foreach (shadow[i]) begin
			shadow[i] = '0;
		end
		repeat (5) @(posedge clk);
		inst_valid <= 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		reset_and_x0();
		build_constants();
		all_imm_ops();
		dependency_chain();
		illegal_encodings();
		idle_cycles();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: exu_top.sv
`default_nettype none

`include "exu_settings.svh"

module exu_top
	import exu_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] inst,
	input  logic        inst_valid,
	output retire_t     retire
);

	decoded_t             dec;
	logic [`EXU_XLEN-1:0] rs1_val;
	wb_t                  wb;

	exu_decoder u_exu_decoder (
		.inst (inst),
		.dec  (dec)
	);

	// Read and decode run in parallel on the same word.
	exu_regfile u_exu_regfile (
		.clk     (clk),
		.reset   (reset),
		.rs1     (dec.rs1),
		.rs1_val (rs1_val),
		.wb      (wb)
	);

	exu_execute u_exu_execute (
		.clk        (clk),
		.reset      (reset),
		.inst_valid (inst_valid),
		.dec        (dec),
		.rs1_val    (rs1_val),
		.wb         (wb),
		.retire     (retire)
	);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module exu_tb -Mdir "$OBJ" -f compile.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$OBJ/Vexu_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
exit 0

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic clk
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period.
	end

endmodule

`default_nettype wire
